// File: id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 12;

    // bit positions in the one-hot alu vector
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // REGIMM selectors in the rt field
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd31;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } j_fields_t;

    // one instruction word in three formats
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_t;

    typedef struct packed {
        inst_t           inst;
        logic [XLEN-1:0] pc;
    } fetch_bus_t;

    // one result source that also serves as the register file write
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       data;
    } fwd_src_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  load_op;
        logic                  mem_we;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_simm;
        logic                  src2_is_zimm;
        logic                  src2_is_8;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [15:0]           imm;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t       ctrl;
        logic [XLEN-1:0] rs_value;
        logic [XLEN-1:0] rt_value;
        logic [XLEN-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

endpackage

`default_nettype wire

// File: id_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module id_ctrl import id_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_to_ds_valid,
    input  fetch_bus_t fs_to_ds_bus,
    input  logic       es_allowin,
    input  logic       load_use,
    output logic       ds_allowin,
    output logic       ds_valid,
    output logic       ds_to_es_valid,
    output fetch_bus_t ds_bus
);

    logic ds_ready;

    // held instruction waits while execute still holds its load
    assign ds_ready       = ~load_use;
    assign ds_allowin     = ~ds_valid | (ds_ready & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // instruction and pc, loaded on a fetch transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  inst_t     inst,
    output dec_ctrl_t ctrl,
    output logic      uses_rs,
    output logic      uses_rt
);

    logic is_special;
    logic is_regimm;
    logic rs_zero;
    logic rt_zero;
    logic rd_zero;
    logic sa_zero;

    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_blez, inst_bgtz, inst_bltz, inst_bgez;
    logic inst_j, inst_jal, inst_jr, inst_jalr;

    logic alu_r;
    logic alu_shift;
    logic alu_imm;
    logic branch;
    logic known;
    logic dst_is_rt;

    assign is_special = inst.r.op == OP_SPECIAL;
    assign is_regimm  = inst.r.op == OP_REGIMM;
    assign rs_zero    = inst.r.rs == '0;
    assign rt_zero    = inst.r.rt == '0;
    assign rd_zero    = inst.r.rd == '0;
    assign sa_zero    = inst.r.sa == '0;

    // register forms need sa clear, shifts need rs clear
    assign inst_addu  = is_special & sa_zero & (inst.r.func == FN_ADDU);
    assign inst_subu  = is_special & sa_zero & (inst.r.func == FN_SUBU);
    assign inst_slt   = is_special & sa_zero & (inst.r.func == FN_SLT);
    assign inst_sltu  = is_special & sa_zero & (inst.r.func == FN_SLTU);
    assign inst_and   = is_special & sa_zero & (inst.r.func == FN_AND);
    assign inst_or    = is_special & sa_zero & (inst.r.func == FN_OR);
    assign inst_xor   = is_special & sa_zero & (inst.r.func == FN_XOR);
    assign inst_nor   = is_special & sa_zero & (inst.r.func == FN_NOR);
    assign inst_sll   = is_special & rs_zero & (inst.r.func == FN_SLL);
    assign inst_srl   = is_special & rs_zero & (inst.r.func == FN_SRL);
    assign inst_sra   = is_special & rs_zero & (inst.r.func == FN_SRA);
    assign inst_jr    = is_special & rt_zero & rd_zero & sa_zero & (inst.r.func == FN_JR);
    assign inst_jalr  = is_special & rt_zero & sa_zero & (inst.r.func == FN_JALR);

    assign inst_addiu = inst.i.op == OP_ADDIU;
    assign inst_slti  = inst.i.op == OP_SLTI;
    assign inst_sltiu = inst.i.op == OP_SLTIU;
    assign inst_andi  = inst.i.op == OP_ANDI;
    assign inst_ori   = inst.i.op == OP_ORI;
    assign inst_xori  = inst.i.op == OP_XORI;
    assign inst_lui   = (inst.i.op == OP_LUI) & rs_zero;
    assign inst_lw    = inst.i.op == OP_LW;
    assign inst_sw    = inst.i.op == OP_SW;
    assign inst_beq   = inst.i.op == OP_BEQ;
    assign inst_bne   = inst.i.op == OP_BNE;
    assign inst_blez  = (inst.i.op == OP_BLEZ) & rt_zero;
    assign inst_bgtz  = (inst.i.op == OP_BGTZ) & rt_zero;
    assign inst_bltz  = is_regimm & (inst.i.rt == RT_BLTZ);
    assign inst_bgez  = is_regimm & (inst.i.rt == RT_BGEZ);
    assign inst_j     = inst.j.op == OP_J;
    assign inst_jal   = inst.j.op == OP_JAL;

    // instruction classes
    assign alu_r     = inst_addu | inst_subu | inst_slt | inst_sltu
                     | inst_and | inst_or | inst_xor | inst_nor;
    assign alu_shift = inst_sll | inst_srl | inst_sra;
    assign alu_imm   = inst_addiu | inst_slti | inst_sltiu | inst_andi
                     | inst_ori | inst_xori | inst_lui;
    assign branch    = inst_beq | inst_bne | inst_blez | inst_bgtz | inst_bltz | inst_bgez;
    assign known     = alu_r | alu_shift | alu_imm | inst_lw | inst_sw | branch
                     | inst_j | inst_jal | inst_jr | inst_jalr;

    // address adds and link adds share the adder
    assign ctrl.alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
    assign ctrl.alu_op[ALU_SUB]  = inst_subu;
    assign ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
    assign ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
    assign ctrl.alu_op[ALU_NOR]  = inst_nor;
    assign ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
    assign ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign ctrl.alu_op[ALU_SLL]  = inst_sll;
    assign ctrl.alu_op[ALU_SRL]  = inst_srl;
    assign ctrl.alu_op[ALU_SRA]  = inst_sra;
    assign ctrl.alu_op[ALU_LUI]  = inst_lui;

    assign ctrl.load_op      = inst_lw;
    assign ctrl.mem_we       = inst_sw;
    assign ctrl.src1_is_sa   = alu_shift;
    assign ctrl.src1_is_pc   = inst_jal | inst_jalr;
    assign ctrl.src2_is_simm = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign ctrl.src2_is_zimm = inst_andi | inst_ori | inst_xori;
    assign ctrl.src2_is_8    = inst_jal | inst_jalr;
    assign ctrl.gr_we        = alu_r | alu_shift | alu_imm | inst_lw | inst_jal | inst_jalr;

    // no destination without a register write
    assign dst_is_rt = alu_imm | inst_lw;
    assign ctrl.dest = !ctrl.gr_we ? '0 :
                       inst_jal    ? REG_RA :
                       dst_is_rt   ? inst.i.rt :
                                     inst.r.rd;
    assign ctrl.imm  = known ? inst.i.imm : '0;

    assign uses_rs = alu_r | (alu_imm & ~inst_lui) | inst_lw | inst_sw | branch
                   | inst_jr | inst_jalr;
    assign uses_rt = alu_r | alu_shift | inst_sw | inst_beq | inst_bne;

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  fwd_src_t              wr
);

    logic [XLEN-1:0] rf [0:(1 << REG_ADDR_W) - 1];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.valid && wr.we && wr.dest != '0) begin
            rf[wr.dest] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

// File: operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs,
    input  logic [REG_ADDR_W-1:0] rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  logic [XLEN-1:0]       rdata1,
    input  logic [XLEN-1:0]       rdata2,
    input  fwd_src_t              es_fwd,
    input  fwd_src_t              ms_fwd,
    input  fwd_src_t              ws_fwd,
    input  logic                  es_load_op,
    output logic [XLEN-1:0]       rs_value,
    output logic [XLEN-1:0]       rt_value,
    output logic                  load_use
);

    function automatic logic hit(input fwd_src_t src, input logic [REG_ADDR_W-1:0] addr);
        return src.valid && src.we && src.dest == addr;
    endfunction

    // youngest result first, register file last
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data,
        input fwd_src_t              es,
        input fwd_src_t              ms,
        input fwd_src_t              ws
    );
        if (addr == '0) begin
            return '0;
        end else if (hit(es, addr)) begin
            return es.data;
        end else if (hit(ms, addr)) begin
            return ms.data;
        end else if (hit(ws, addr)) begin
            return ws.data;
        end
        return rf_data;
    endfunction

    assign rs_value = pick(rs, rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rt_value = pick(rt, rdata2, es_fwd, ms_fwd, ws_fwd);

    // load data only exists after memory, so execute cannot forward it
    assign load_use = es_load_op && es_fwd.dest != '0
                   && ((hit(es_fwd, rs) && uses_rs) || (hit(es_fwd, rt) && uses_rt));

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
    input  inst_t           inst,
    input  logic [XLEN-1:0] pc,
    input  logic            ds_valid,
    input  logic [XLEN-1:0] rs_value,
    input  logic [XLEN-1:0] rt_value,
    output br_bus_t         br_bus
);

    logic [XLEN-1:0] pc_plus4;
    logic            is_cond;
    logic            is_jump;
    logic            is_jreg;
    logic            rs_eq_rt;
    logic            rs_neg;
    logic            rs_zero;
    logic            cond_met;

    // delay slot address
    assign pc_plus4 = pc + 32'd4;

    assign rs_eq_rt = rs_value == rt_value;
    assign rs_neg   = rs_value[XLEN-1];
    assign rs_zero  = rs_value == '0;

    always_comb begin
        cond_met = 1'b0;
        case (inst.i.op)
            OP_BEQ:    cond_met = rs_eq_rt;
            OP_BNE:    cond_met = ~rs_eq_rt;
            OP_BLEZ:   cond_met = (inst.i.rt == '0) & (rs_neg | rs_zero);
            OP_BGTZ:   cond_met = (inst.i.rt == '0) & ~rs_neg & ~rs_zero;
            OP_REGIMM: begin
                if (inst.i.rt == RT_BLTZ) begin
                    cond_met = rs_neg;
                end else if (inst.i.rt == RT_BGEZ) begin
                    cond_met = ~rs_neg;
                end
            end
            default:   cond_met = 1'b0;
        endcase
    end

    assign is_cond = (inst.i.op == OP_BEQ) | (inst.i.op == OP_BNE) | (inst.i.op == OP_BLEZ)
                   | (inst.i.op == OP_BGTZ) | (inst.i.op == OP_REGIMM);
    assign is_jump = (inst.j.op == OP_J) | (inst.j.op == OP_JAL);
    assign is_jreg = (inst.r.op == OP_SPECIAL) & (inst.r.rt == '0) & (inst.r.sa == '0)
                   & (((inst.r.func == FN_JR) & (inst.r.rd == '0)) | (inst.r.func == FN_JALR));

    assign br_bus.taken  = ds_valid & (cond_met | is_jump | is_jreg);
    assign br_bus.target = is_cond ? pc_plus4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00} :
                           is_jreg ? rs_value :
                                     {pc_plus4[31:28], inst.j.index, 2'b00};

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_to_ds_valid,
    input  fetch_bus_t fs_to_ds_bus,
    input  logic       es_allowin,
    input  fwd_src_t   es_fwd,
    input  fwd_src_t   ms_fwd,
    input  fwd_src_t   ws_fwd,
    input  logic       es_load_op,
    output logic       ds_allowin,
    output logic       ds_to_es_valid,
    output ds_to_es_t  ds_to_es_bus,
    output br_bus_t    br_bus
);

    fetch_bus_t      ds_bus;
    logic            ds_valid;
    logic            load_use;
    dec_ctrl_t       ctrl;
    logic            uses_rs;
    logic            uses_rt;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] rs_value;
    logic [XLEN-1:0] rt_value;

    id_ctrl u_id_ctrl (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .load_use       (load_use),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_bus         (ds_bus)
    );

    inst_decoder u_inst_decoder (
        .inst    (ds_bus.inst),
        .ctrl    (ctrl),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt)
    );

    // writeback result doubles as the register write port
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ds_bus.inst.r.rs),
        .raddr2 (ds_bus.inst.r.rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (ws_fwd)
    );

    operand_forward u_operand_forward (
        .rs         (ds_bus.inst.r.rs),
        .rt         (ds_bus.inst.r.rt),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_use   (load_use)
    );

    branch_unit u_branch_unit (
        .inst     (ds_bus.inst),
        .pc       (ds_bus.pc),
        .ds_valid (ds_valid),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br_bus   (br_bus)
    );

    assign ds_to_es_bus.ctrl     = ctrl;
    assign ds_to_es_bus.rs_value = rs_value;
    assign ds_to_es_bus.rt_value = rt_value;
    assign ds_to_es_bus.pc       = ds_bus.pc;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 50;

    // 100 ns period
    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int HANDSHAKE_LIMIT = 50;

    logic       clk;
    logic       reset;
    logic       fs_to_ds_valid;
    fetch_bus_t fs_to_ds_bus;
    logic       es_allowin;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    fwd_src_t   ws_fwd;
    logic       es_load_op;
    logic       ds_allowin;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    br_bus_t    br_bus;

    // expected register contents with r0 held at zero
    logic [XLEN-1:0] model_regs [0:31];

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .es_load_op     (es_load_op),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus)
    );

    function automatic logic [31:0] r_word(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] sa,
        input logic [5:0] func
    );
        return {OP_SPECIAL, rs, rt, rd, sa, func};
    endfunction

    function automatic logic [31:0] i_word(
        input logic [5:0]  op,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic fwd_src_t make_src(input logic [4:0] dest, input logic [31:0] data);
        return {1'b1, 1'b1, dest, data};
    endfunction

    // delay slot pc plus a word offset
    function automatic logic [31:0] branch_dest(input logic [31:0] pc, input logic [15:0] imm);
        logic signed [31:0] offset;
        offset = $signed(imm);
        return pc + 32'd4 + (offset <<< 2);
    endfunction

    // region of the delay slot with the index in words
    function automatic logic [31:0] jump_dest(input logic [31:0] pc, input logic [25:0] index);
        logic [31:0] slot;
        slot = pc + 32'd4;
        return {slot[31:28], index, 2'b00};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(
        input string        name,
        input logic [135:0] actual,
        input logic [135:0] expected
    );
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_sources(
        input fwd_src_t es,
        input fwd_src_t ms,
        input fwd_src_t ws,
        input logic     load
    );
        @(posedge clk);
        es_fwd     <= es;
        ms_fwd     <= ms;
        ws_fwd     <= ws;
        es_load_op <= load;
        if (ws.valid && ws.we && ws.dest != 5'd0) begin
            model_regs[ws.dest] = ws.data;
        end
    endtask

    // returns at the falling edge after the fetch transfer
    task automatic send_inst(input logic [31:0] word, input logic [31:0] pc);
        int waited;
        waited = 0;
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds_bus   <= {word, pc};
        @(negedge clk);
        while (!ds_allowin && waited < HANDSHAKE_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!ds_allowin) begin
            fail_run("decode stage never accepted the instruction from fetch");
        end
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_value("br_bus.taken", br_bus.taken, 1'b0);
        check_value("ds_allowin", ds_allowin, 1'b1);
    endtask

    task automatic decode_case(
        input logic [31:0] word,
        input logic [31:0] pc,
        input int          alu_bit,
        input logic        load_op,
        input logic        mem_we,
        input logic        src1_is_sa,
        input logic        src2_is_simm,
        input logic        gr_we,
        input logic [4:0]  dest
    );
        dec_ctrl_t exp;
        exp                 = '0;
        exp.alu_op[alu_bit] = 1'b1;
        exp.load_op         = load_op;
        exp.mem_we          = mem_we;
        exp.src1_is_sa      = src1_is_sa;
        exp.src2_is_simm    = src2_is_simm;
        exp.gr_we           = gr_we;
        exp.dest            = dest;
        exp.imm             = word[15:0];
        send_inst(word, pc);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_to_es_bus.ctrl", ds_to_es_bus.ctrl, exp);
        check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, pc);
    endtask

    task automatic decode_fields();
        decode_case(i_word(OP_ADDIU, 5'd3, 5'd5, 16'h1234), 32'h0000_1000,
                    ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 5'd5);
        decode_case(r_word(5'd2, 5'd3, 5'd8, 5'd0, FN_OR), 32'h0000_1004,
                    ALU_OR, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd8);
        decode_case(r_word(5'd0, 5'd4, 5'd9, 5'd3, FN_SLL), 32'h0000_1008,
                    ALU_SLL, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 5'd9);
        decode_case(i_word(OP_LUI, 5'd0, 5'd10, 16'habcd), 32'h0000_100c,
                    ALU_LUI, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 5'd10);
        decode_case(i_word(OP_LW, 5'd2, 5'd11, 16'h0008), 32'h0000_1010,
                    ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 5'd11);
        // store writes no register
        decode_case(i_word(OP_SW, 5'd2, 5'd12, 16'hfffc), 32'h0000_1014,
                    ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 5'd0);
    endtask

    task automatic read_pair(input logic [4:0] rs, input logic [4:0] rt);
        send_inst(r_word(rs, rt, 5'd1, 5'd0, FN_ADDU), 32'h0000_2000);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, model_regs[rs]);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, model_regs[rt]);
    endtask

    task automatic regfile_readback();
        set_sources('0, '0, make_src(5'd3, $urandom()), 1'b0);
        set_sources('0, '0, make_src(5'd5, $urandom()), 1'b0);
        set_sources('0, '0, make_src(5'd9, $urandom()), 1'b0);
        set_sources('0, '0, make_src(5'd17, $urandom()), 1'b0);
        set_sources('0, '0, make_src(5'd30, $urandom()), 1'b0);
        set_sources('0, '0, make_src(5'd0, $urandom()), 1'b0);
        set_sources('0, '0, '0, 1'b0);
        read_pair(5'd3, 5'd5);
        read_pair(5'd9, 5'd17);
        read_pair(5'd30, 5'd0);
        read_pair(5'd0, 5'd9);
    endtask

    task automatic forwarding_priority();
        logic [31:0] word;
        word = r_word(5'd7, 5'd7, 5'd2, 5'd0, FN_OR);
        set_sources(make_src(5'd7, 32'h1111_1111), make_src(5'd7, 32'h2222_2222),
                    make_src(5'd7, 32'h3333_3333), 1'b0);
        send_inst(word, 32'h0000_2100);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, 32'h1111_1111);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, 32'h1111_1111);
        set_sources('0, make_src(5'd7, 32'h2222_2222), make_src(5'd7, 32'h3333_3333), 1'b0);
        send_inst(word, 32'h0000_2104);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, 32'h2222_2222);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, 32'h2222_2222);
        // writeback data reaches the operands a cycle before it lands in r7
        set_sources('0, '0, '0, 1'b0);
        @(posedge clk);
        es_allowin <= 1'b0;
        send_inst(word, 32'h0000_2108);
        set_sources('0, '0, make_src(5'd7, 32'h7777_7777), 1'b0);
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, 32'h7777_7777);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, 32'h7777_7777);
        @(posedge clk);
        es_allowin <= 1'b1;
        // sources aimed at r0 must not leak through
        set_sources(make_src(5'd0, 32'h4444_4444), make_src(5'd0, 32'h5555_5555),
                    make_src(5'd0, 32'h6666_6666), 1'b0);
        send_inst(r_word(5'd0, 5'd0, 5'd2, 5'd0, FN_OR), 32'h0000_210c);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, 32'h0);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, 32'h0);
        set_sources('0, '0, '0, 1'b0);
    endtask

    task automatic stall_and_backpressure();
        ds_to_es_t held;
        // load in execute targets r6
        set_sources(make_src(5'd6, 32'hdead_0006), '0, '0, 1'b1);
        send_inst(r_word(5'd6, 5'd0, 5'd4, 5'd0, FN_ADDU), 32'h0000_3000);
        repeat (3) begin
            check_value("ds_to_es_valid", ds_to_es_valid, 1'b0);
            check_value("ds_allowin", ds_allowin, 1'b0);
            @(negedge clk);
        end
        set_sources('0, '0, '0, 1'b0);
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_allowin", ds_allowin, 1'b1);
        check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, 32'h0000_3000);
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b0);

        // execute refuses while a second instruction waits in fetch
        @(posedge clk);
        es_allowin <= 1'b0;
        send_inst(i_word(OP_ORI, 5'd0, 5'd3, 16'h0055), 32'h0000_3100);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_allowin", ds_allowin, 1'b0);
        check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, 32'h0000_3100);
        held = ds_to_es_bus;
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds_bus   <= {i_word(OP_ORI, 5'd0, 5'd4, 16'h0066), 32'h0000_3104};
        repeat (3) begin
            @(negedge clk);
            check_value("ds_to_es_bus", ds_to_es_bus, held);
            check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
            check_value("ds_allowin", ds_allowin, 1'b0);
        end
        @(posedge clk);
        es_allowin <= 1'b1;
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, 32'h0000_3104);
    endtask

    // rs comes from execute as r1, rt from memory as r2
    task automatic branch_case(
        input logic [31:0] word,
        input logic [31:0] pc,
        input logic [31:0] rs_val,
        input logic [31:0] rt_val,
        input logic        exp_taken,
        input logic [31:0] exp_target
    );
        set_sources(make_src(5'd1, rs_val), make_src(5'd2, rt_val), '0, 1'b0);
        send_inst(word, pc);
        check_value("br_bus.taken", br_bus.taken, exp_taken);
        check_value("br_bus.target", br_bus.target, exp_target);
    endtask

    task automatic branch_resolution();
        logic [31:0] word;
        logic [31:0] dest;
        word = i_word(OP_BEQ, 5'd1, 5'd2, 16'h0010);
        dest = branch_dest(32'h0000_1000, 16'h0010);
        branch_case(word, 32'h0000_1000, 32'h5, 32'h5, 1'b1, dest);
        branch_case(word, 32'h0000_1000, 32'h5, 32'h6, 1'b0, dest);
        word = i_word(OP_REGIMM, 5'd1, RT_BLTZ, 16'hfff8);
        dest = branch_dest(32'h0000_2000, 16'hfff8);
        branch_case(word, 32'h0000_2000, 32'hffff_fffd, 32'h0, 1'b1, dest);
        branch_case(word, 32'h0000_2000, 32'h0, 32'h0, 1'b0, dest);
        branch_case(word, 32'h0000_2000, 32'h7, 32'h0, 1'b0, dest);
        word = i_word(OP_BLEZ, 5'd1, 5'd0, 16'h0004);
        dest = branch_dest(32'h0000_2400, 16'h0004);
        branch_case(word, 32'h0000_2400, 32'h8000_0000, 32'h0, 1'b1, dest);
        branch_case(word, 32'h0000_2400, 32'h0, 32'h0, 1'b1, dest);
        branch_case(word, 32'h0000_2400, 32'h1, 32'h0, 1'b0, dest);
        word = i_word(OP_BGTZ, 5'd1, 5'd0, 16'h0020);
        dest = branch_dest(32'h0000_2800, 16'h0020);
        branch_case(word, 32'h0000_2800, 32'hffff_ffff, 32'h0, 1'b0, dest);
        branch_case(word, 32'h0000_2800, 32'h0, 32'h0, 1'b0, dest);
        branch_case(word, 32'h0000_2800, 32'h1234, 32'h0, 1'b1, dest);
        // pc+4 crosses into the next 256 MB region
        branch_case(j_word(OP_J, 26'h012_3456), 32'h4fff_fffc, 32'h0, 32'h0, 1'b1,
                    jump_dest(32'h4fff_fffc, 26'h012_3456));
        branch_case(j_word(OP_JAL, 26'h3ff_fff0), 32'h0040_0100, 32'h0, 32'h0, 1'b1,
                    jump_dest(32'h0040_0100, 26'h3ff_fff0));
        branch_case(r_word(5'd1, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0040_0200, 32'h0040_2000,
                    32'h0, 1'b1, 32'h0040_2000);
        set_sources('0, '0, '0, 1'b0);
    endtask

    initial begin
        void'($urandom(21847));
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_fwd         = '0;
        es_load_op     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        decode_fields();
        regfile_readback();
        forwarding_priority();
        stall_and_backpressure();
        branch_resolution();
        $display("sim passed");
        $finish;
    end

    // bound on the whole run
    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * TEST_COUNT);
        $display("timeout: tests did not finish within %0d cycles", CYCLES_PER_TEST * TEST_COUNT);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: project.f
id_pkg.sv
id_ctrl.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
tb_clock_gen.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
TOP       ?= tb_id_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
